// ==== source/cart_loader_pkg.sv ====
/*
 * Cartridge loader shared definitions
 * Widths, memory bases, iNES magic, file types and mapper flag layout
 */
package cart_loader_pkg;

	//////////////////////////////////////////////////
	// Types

	typedef logic [7:0]   byte_t;          // Download and memory data
	typedef logic [21:0]  mem_addr_t;      // Cartridge memory byte address
	typedef logic [21:0]  byte_count_t;    // Bytes still to load
	typedef logic [3:0]   header_index_t;  // Position within the header
	typedef logic [2:0]   size_code_t;     // Log2 ROM size code
	typedef logic [31:0]  mapper_flags_t;  // Packed cartridge description
	typedef logic [127:0] cheat_code_t;    // Flags, address, compare, replace

	//////////////////////////////////////////////////
	// Image layout

	localparam int HEADER_BYTES   = 16;
	localparam int PRG_PAGE_SHIFT = 14;  // 16 KiB PRG pages
	localparam int CHR_PAGE_SHIFT = 13;  // 8 KiB CHR pages

	// Where each section lands in cartridge memory
	localparam mem_addr_t PRG_BASE = 22'h000000;
	localparam mem_addr_t CHR_BASE = 22'h200000;

	// "NES" followed by MS-DOS end of file
	localparam byte_t INES_MAGIC_0 = 8'h4E;
	localparam byte_t INES_MAGIC_1 = 8'h45;
	localparam byte_t INES_MAGIC_2 = 8'h53;
	localparam byte_t INES_MAGIC_3 = 8'h1A;

	//////////////////////////////////////////////////
	// Host file types

	localparam byte_t FILETYPE_CHEAT = 8'hFF;  // Everything else is a ROM image

	//////////////////////////////////////////////////
	// Mapper flag word fields

	// Bits 7:0 mapper number
	localparam int MF_MAPPER_LSB = 0;
	// Bits 10:8 and 13:11 size codes
	localparam int MF_PRG_SIZE_LSB = 8;
	localparam int MF_CHR_SIZE_LSB = 11;
	localparam int MF_MIRROR_BIT      = 14;  // Vertical when set
	localparam int MF_CHR_RAM_BIT     = 15;  // No CHR ROM in image
	localparam int MF_FOUR_SCREEN_BIT = 16;
	// Bits 24:17 raw NES 2.0 byte 8 (mapper high bits and submapper)
	localparam int MF_NES20_LSB = 17;
	localparam int MF_BATTERY_BIT = 25;  // Battery backed save RAM

	// Bits 31:26 stay zero

endpackage

// ==== source/ines_header_parser.sv ====
/*
 * iNES header parser
 * Keeps the 16 header bytes and decodes validity, page counts and the
 * packed mapper flag word used by the console core
 */
module ines_header_parser
	import cart_loader_pkg::*;
(
	input  logic          clk,
	input  logic          header_strobe,
	input  header_index_t header_index,
	input  byte_t         data,
	input  logic          invert_mirroring,
	output logic          header_ok,
	output byte_t         prg_pages,
	output byte_t         chr_pages,
	output mapper_flags_t mapper_flags
);

	byte_t hdr [HEADER_BYTES];  // Raw header bytes

	logic is_nes20;
	logic is_dirty;
	byte_t mapper_num;

	// Smallest k with pages <= 2**k, capped at 7
	function automatic size_code_t size_code(input byte_t pages);
		size_code_t k;
		k = 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (int'(pages) <= (1 << i))
				k = size_code_t'(i);
		end
		return k;
	endfunction

	always_ff @(posedge clk) begin
		if (header_strobe)
			hdr[header_index] <= data;
	end

	//////////////////////////////////////////////////
	// Field decode

	// Trainers are not supported
	assign header_ok = (hdr[0] == INES_MAGIC_0) && (hdr[1] == INES_MAGIC_1) &&
		(hdr[2] == INES_MAGIC_2) && (hdr[3] == INES_MAGIC_3) && !hdr[6][2];

	assign prg_pages = hdr[4];  // 16 KiB units
	assign chr_pages = hdr[5];  // 8 KiB units, 0 means CHR RAM

	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	// Old dumps often carry junk in the tail of an iNES 1.0 header
	assign is_dirty = !is_nes20 && ((hdr[9][7:1] != 7'd0) ||
		(hdr[10] != 8'h00) || (hdr[11] != 8'h00) ||
		(hdr[12] != 8'h00) || (hdr[13] != 8'h00) ||
		(hdr[14] != 8'h00) || (hdr[15] != 8'h00));

	// Upper nibble is untrustworthy in a dirty header
	assign mapper_num = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};

	//////////////////////////////////////////////////
	// Flag word packing

	always_comb begin
		mapper_flags = '0;
		mapper_flags[MF_MAPPER_LSB +: $bits(byte_t)] = mapper_num;
		mapper_flags[MF_PRG_SIZE_LSB +: $bits(size_code_t)] = size_code(prg_pages);
		mapper_flags[MF_CHR_SIZE_LSB +: $bits(size_code_t)] = size_code(chr_pages);
		mapper_flags[MF_MIRROR_BIT] = hdr[6][0] ^ invert_mirroring;
		mapper_flags[MF_CHR_RAM_BIT] = (chr_pages == 8'h00);
		mapper_flags[MF_FOUR_SCREEN_BIT] = hdr[6][3];
		mapper_flags[MF_NES20_LSB +: $bits(byte_t)] = is_nes20 ? hdr[8] : 8'h00;
		mapper_flags[MF_BATTERY_BIT] = hdr[6][1];  // Saves need backing up
	end

endmodule

// ==== source/rom_load_sequencer.sv ====
/*
 * ROM load sequencer
 * Counts header, PRG and CHR bytes of an iNES image and turns each
 * payload byte into a cartridge memory write
 */
module rom_load_sequencer
	import cart_loader_pkg::*;
(
	input  logic          clk,
	input  logic          reset_nes,
	input  logic          active,
	input  byte_t         data,
	input  logic          strobe,
	input  logic          header_ok,
	input  byte_t         prg_pages,
	input  byte_t         chr_pages,
	output logic          header_strobe,
	output header_index_t header_index,
	output mem_addr_t     mem_addr,
	output byte_t         mem_data,
	output logic          mem_write,
	output logic          busy,
	output logic          done,
	output logic          error
);

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_ERROR,
		LOAD_DONE
	} load_state_t;

	load_state_t   state;
	logic          active_q;
	logic          start;         // New file begins
	header_index_t header_count;
	byte_count_t   bytes_left;    // Left in current section

	assign start = active & ~active_q;

	// Bytes arriving in the restart cycle are dropped
	assign header_strobe = strobe & ~start & (state == LOAD_HEADER);
	assign header_index  = header_count;

	assign mem_write = strobe & ~start & ((state == LOAD_PRG) | (state == LOAD_CHR));
	assign mem_data  = data;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state        <= LOAD_HEADER;
			active_q     <= 1'b0;
			header_count <= '0;
			busy         <= 1'b0;
			done         <= 1'b0;
			error        <= 1'b0;
		end else begin
			active_q <= active;
			if (start) begin
				state        <= LOAD_HEADER;
				header_count <= '0;
				busy         <= 1'b0;
				done         <= 1'b0;
				error        <= 1'b0;
			end else begin
				case (state)
					LOAD_HEADER: if (strobe) begin
						header_count <= header_count + 1'b1;
						if (header_count == header_index_t'(HEADER_BYTES - 1)) begin
							if (!header_ok) begin
								state <= LOAD_ERROR;
							end else begin
								busy <= 1'b1;
								// Skip empty sections straight away
								if (prg_pages != 8'h00) begin
									state      <= LOAD_PRG;
									mem_addr   <= PRG_BASE;
									bytes_left <= byte_count_t'(prg_pages) << PRG_PAGE_SHIFT;
								end else if (chr_pages != 8'h00) begin
									state      <= LOAD_CHR;
									mem_addr   <= CHR_BASE;
									bytes_left <= byte_count_t'(chr_pages) << CHR_PAGE_SHIFT;
								end else begin
									state <= LOAD_DONE;
								end
							end
						end
					end
					LOAD_PRG: if (strobe) begin
						mem_addr   <= mem_addr + 1'b1;
						bytes_left <= bytes_left - 1'b1;
						if (bytes_left == byte_count_t'(1)) begin  // Last PRG byte
							if (chr_pages != 8'h00) begin
								state      <= LOAD_CHR;
								mem_addr   <= CHR_BASE;
								bytes_left <= byte_count_t'(chr_pages) << CHR_PAGE_SHIFT;
							end else begin
								state <= LOAD_DONE;
							end
						end
					end
					LOAD_CHR: if (strobe) begin
						mem_addr   <= mem_addr + 1'b1;
						bytes_left <= bytes_left - 1'b1;
						if (bytes_left == byte_count_t'(1))
							state <= LOAD_DONE;
					end
					LOAD_ERROR: begin  // Bad magic or trainer
						done  <= 1'b1;
						error <= 1'b1;
						busy  <= 1'b0;
					end
					default: begin  // Extra bytes ignored until next file
						done <= 1'b1;
						busy <= 1'b0;
					end
				endcase
			end
		end
	end

endmodule

// ==== source/cheat_code_assembler.sv ====
/*
 * Cheat code assembler
 * Packs a 16-byte cheat file into the 128-bit code and pulses a load
 */
module cheat_code_assembler
	import cart_loader_pkg::*;
(
	input  logic        clk,
	input  logic        reset_nes,
	input  logic        strobe,
	input  logic [3:0]  byte_index,
	input  byte_t       data,
	output cheat_code_t cheat_code,
	output logic        cheat_load
);

	logic [1:0] field;      // 0 flags .. 3 replace
	logic [1:0] field_byte; // Little-endian byte within field
	logic [6:0] bit_pos;

	assign field      = byte_index[3:2];
	assign field_byte = byte_index[1:0];

	// Flags end up on top, replace at the bottom
	assign bit_pos = {~field, field_byte, 3'b000};

	//////////////////////////////////////////////////
	// Code register and load strobe

	always_ff @(posedge clk) begin
		if (strobe)
			cheat_code[bit_pos +: 8] <= data;
	end

	always_ff @(posedge clk) begin
		if (reset_nes)
			cheat_load <= 1'b0;
		else
			cheat_load <= strobe & (byte_index == 4'hF);  // Code complete
	end

endmodule

// ==== source/cart_loader_top.sv ====
/*
 * Cartridge loader top level
 * Steers the host download into the ROM image path or the cheat path
 */
module cart_loader_top
	import cart_loader_pkg::*;
(
	input  logic          clk,
	input  logic          reset_nes,
	input  logic          download_active,
	input  byte_t         download_type,
	input  mem_addr_t     download_addr,
	input  byte_t         download_data,
	input  logic          download_strobe,
	input  logic          invert_mirroring,
	output mem_addr_t     mem_addr,
	output byte_t         mem_data,
	output logic          mem_write,
	output logic          load_busy,
	output logic          load_done,
	output logic          load_error,
	output mapper_flags_t mapper_flags,
	output cheat_code_t   cheat_code,
	output logic          cheat_load
);

	logic          is_cheat;
	logic          rom_active;
	logic          rom_strobe;
	logic          cheat_strobe;
	logic          header_strobe;
	header_index_t header_index;
	logic          header_ok;
	byte_t         prg_pages;
	byte_t         chr_pages;

	// File type decides the path for the whole download
	assign is_cheat     = (download_type == FILETYPE_CHEAT);
	assign rom_active   = download_active & ~is_cheat;
	assign rom_strobe   = download_strobe & rom_active;
	assign cheat_strobe = download_strobe & download_active & is_cheat;

	//////////////////////////////////////////////////
	// ROM image path

	rom_load_sequencer i_sequencer (
		.clk(clk), .reset_nes(reset_nes), .active(rom_active),
		.data(download_data), .strobe(rom_strobe), .header_ok(header_ok),
		.prg_pages(prg_pages), .chr_pages(chr_pages),
		.header_strobe(header_strobe), .header_index(header_index),
		.mem_addr(mem_addr), .mem_data(mem_data), .mem_write(mem_write),
		.busy(load_busy), .done(load_done), .error(load_error)
	);

	ines_header_parser i_parser (
		.clk(clk), .header_strobe(header_strobe), .header_index(header_index),
		.data(download_data), .invert_mirroring(invert_mirroring),
		.header_ok(header_ok), .prg_pages(prg_pages), .chr_pages(chr_pages),
		.mapper_flags(mapper_flags)
	);

	// Cheat path
	cheat_code_assembler i_cheat (
		.clk(clk), .reset_nes(reset_nes), .strobe(cheat_strobe),
		.byte_index(download_addr[3:0]), .data(download_data),
		.cheat_code(cheat_code), .cheat_load(cheat_load)
	);

endmodule

// ==== tests/tb_cart_loader.sv ====
/*
 * Cartridge loader testbench
 * Streams iNES images and a cheat file into the loader and checks
 * memory writes, status, mapper flags and the cheat code
 */
module tb_cart_loader
	import cart_loader_pkg::*;
;

	localparam int ERROR_TAIL = 32;  // Bytes sent after a rejected header

	// Two payload images, dirty header, two rejected images with a tail, cheat file
	localparam int TOTAL_BYTES = (16 + 16384 + 8192) + (16 + 32768) + 16 +
		2 * (16 + ERROR_TAIL) + 16;
	localparam int CYCLE_LIMIT = 4 * TOTAL_BYTES + 1000;

	logic          clk;
	logic          reset_nes;
	logic          download_active;
	byte_t         download_type;
	mem_addr_t     download_addr;
	byte_t         download_data;
	logic          download_strobe;
	logic          invert_mirroring;
	mem_addr_t     mem_addr;
	byte_t         mem_data;
	logic          mem_write;
	logic          load_busy;
	logic          load_done;
	logic          load_error;
	mapper_flags_t mapper_flags;
	cheat_code_t   cheat_code;
	logic          cheat_load;

	integer        seed;
	int            cycles;
	int            strobe_count;        // Strobes seen in current file
	int            final_strobe;        // Strobe that ends the image
	int            final_strobe_cycle;
	byte_t         payload[$];     // PRG then CHR bytes of current image
	int            prg_bytes;
	int            expect_writes;
	int            write_count;
	int            cheat_count;
	logic          exp_ok;
	logic          done_q;
	logic          done_seen;
	mapper_flags_t exp_flags;
	cheat_code_t   exp_cheat;
	logic [127:0]  hdr;
	logic [127:0]  cheat_bytes;
	logic          done_before;

	cart_loader_top i_dut (
		.clk(clk), .reset_nes(reset_nes), .download_active(download_active),
		.download_type(download_type), .download_addr(download_addr),
		.download_data(download_data), .download_strobe(download_strobe),
		.invert_mirroring(invert_mirroring), .mem_addr(mem_addr), .mem_data(mem_data),
		.mem_write(mem_write), .load_busy(load_busy), .load_done(load_done),
		.load_error(load_error), .mapper_flags(mapper_flags),
		.cheat_code(cheat_code), .cheat_load(cheat_load)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the loader did not finish within %0d cycles", CYCLE_LIMIT);
			$display("RESULT: FAIL");
			$fatal(1, "simulation stopped after timeout");
		end
	end

	task automatic check(input logic [127:0] actual, input logic [127:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("CHECK FAILED at time %0t: %s (got %0h, expected %0h)",
				$time, msg, actual, expected);
			$display("RESULT: FAIL");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	//////////////////////////////////////////////////
	// Reference model

	// Smallest k with pages <= 2**k, at most 7
	function automatic size_code_t ref_size(input byte_t pages);
		int k;
		k = 0;
		while (k < 7 && int'(pages) > (1 << k))
			k++;
		return size_code_t'(k);
	endfunction

	function automatic logic ref_header_ok(input logic [127:0] h);
		return h[31:0] == 32'h1A53454E && !h[50];  // Magic and no trainer
	endfunction

	function automatic mapper_flags_t ref_flags(input logic [127:0] h, input logic inv);
		byte_t b6, b7;
		logic nes20;
		logic dirty;
		mapper_flags_t f;
		b6 = h[55:48];
		b7 = h[63:56];
		nes20 = (b7[3:2] == 2'b10);
		dirty = !nes20 && (h[79:73] != 0 || h[127:80] != 0);
		f = '0;
		f[7:0] = {dirty ? 4'h0 : b7[7:4], b6[7:4]};
		f[10:8] = ref_size(h[39:32]);
		f[13:11] = ref_size(h[47:40]);
		f[14] = b6[0] ^ inv;
		f[15] = (h[47:40] == 8'h00);  // CHR RAM
		f[16] = b6[3];
		f[24:17] = nes20 ? h[71:64] : 8'h00;
		f[25] = b6[1];
		return f;
	endfunction

	function automatic mem_addr_t payload_addr(input int n);
		if (n < prg_bytes)
			return PRG_BASE + mem_addr_t'(n);
		return CHR_BASE + mem_addr_t'(n - prg_bytes);
	endfunction

	// Four little-endian fields, flags on top
	function automatic cheat_code_t ref_cheat(input logic [127:0] c);
		cheat_code_t code;
		for (int i = 0; i < 16; i++)
			code[(3 - i / 4) * 32 + (i % 4) * 8 +: 8] = c[8 * i +: 8];
		return code;
	endfunction

	function automatic logic [127:0] make_header(input byte_t prg, input byte_t chr,
			input byte_t f6, input byte_t f7, input byte_t f8, input logic [55:0] tail);
		return {tail, f8, f7, f6, chr, prg, INES_MAGIC_3, INES_MAGIC_2,
			INES_MAGIC_1, INES_MAGIC_0};
	endfunction

	//////////////////////////////////////////////////
	// Compare process

	always @(posedge clk) begin
		if (!reset_nes) begin
			if (download_strobe) begin
				strobe_count++;
				if (strobe_count == final_strobe)
					final_strobe_cycle = cycles;
			end
			if (mem_write) begin
				check(write_count < expect_writes, 1'b1, "unexpected memory write");
				check(load_busy, 1'b1, "load_busy during payload");
				check(mem_addr, payload_addr(write_count), "memory address");
				check(mem_data, payload[write_count], "memory data");
				write_count++;
			end
			if (load_done && !done_q) begin
				check(strobe_count >= final_strobe, 1'b1, "load_done before the last byte");
				check(cycles - final_strobe_cycle <= 2, 1'b1, "load_done latency");
				check(load_error, !exp_ok, "load_error");
				check(write_count, expect_writes, "writes before load_done");
				if (exp_ok)
					check(mapper_flags, exp_flags, "mapper_flags");
				done_seen = 1'b1;
			end
			if (cheat_load) begin
				cheat_count++;
				check(cheat_code, exp_cheat, "cheat_code");
			end
			done_q = load_done;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus

	task automatic stream_byte(input mem_addr_t addr, input byte_t d);
		int gap;
		gap = $unsigned($random(seed)) % 3;
		repeat (gap) @(negedge clk);
		download_addr   = addr;
		download_data   = d;
		download_strobe = 1'b1;
		@(negedge clk);
		download_strobe = 1'b0;
	endtask

	task automatic load_image(input logic [127:0] h, input logic inv);
		int n_bytes;
		int n_sent;
		exp_ok = ref_header_ok(h);
		exp_flags = ref_flags(h, inv);
		prg_bytes = int'(h[39:32]) * 16384;
		n_bytes = exp_ok ? prg_bytes + int'(h[47:40]) * 8192 : 0;
		// Rejected image still streams a tail that must not reach memory
		n_sent = exp_ok ? n_bytes : ERROR_TAIL;
		payload.delete();
		repeat (n_sent) payload.push_back(byte_t'($random(seed)));
		expect_writes = n_bytes;
		write_count = 0;
		strobe_count = 0;
		final_strobe = HEADER_BYTES + n_bytes;
		done_seen = 1'b0;
		invert_mirroring = inv;
		download_type = 8'h00;
		download_active = 1'b1;
		@(negedge clk);  // First byte after the restart cycle
		for (int i = 0; i < HEADER_BYTES; i++)
			stream_byte(mem_addr_t'(i), h[8 * i +: 8]);
		for (int n = 0; n < n_sent; n++)
			stream_byte(mem_addr_t'(HEADER_BYTES + n), payload[n]);
		wait (done_seen);
		repeat (3) @(negedge clk);
		check(write_count, expect_writes, "number of memory writes");
		download_active = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	initial begin
		seed = 24139;
		cycles = 0;
		strobe_count = 0;
		final_strobe = 0;
		final_strobe_cycle = 0;
		write_count = 0;
		expect_writes = 0;
		cheat_count = 0;
		done_q = 1'b0;
		reset_nes = 1'b1;
		download_active = 1'b0;
		download_type = 8'h00;
		download_addr = '0;
		download_data = 8'h00;
		download_strobe = 1'b0;
		invert_mirroring = 1'b0;
		repeat (5) @(negedge clk);
		reset_nes = 1'b0;
		@(negedge clk);
		check({mem_write, load_busy, load_done, load_error, cheat_load}, 5'b0,
			"outputs idle after reset");

		load_image(make_header(8'd1, 8'd1, 8'h13, 8'h00, 8'h00, '0), 1'b0);

		// NES 2.0, PRG only, mirroring inverted
		hdr = make_header(8'd2, 8'd0, 8'h19, 8'h48, 8'h21, 56'h0000_0000_0007F0);
		load_image(hdr, 1'b1);
		check(mapper_flags[MF_CHR_RAM_BIT], 1'b1, "CHR RAM bit");
		invert_mirroring = 1'b0;
		@(negedge clk);
		check(mapper_flags, ref_flags(hdr, 1'b0), "flags with mirroring restored");

		// Dirty 1.0 header loses mapper high nibble
		load_image(make_header(8'd0, 8'd0, 8'h30, 8'h50, 8'h00, 56'h00AB_0000_0000_00), 1'b0);
		check(mapper_flags[7:4], 4'h0, "dirty header mapper high nibble");

		hdr = make_header(8'd1, 8'd1, 8'h00, 8'h00, 8'h00, '0);
		hdr[15:8] = 8'h46;  // Bad second magic byte
		load_image(hdr, 1'b0);
		load_image(make_header(8'd1, 8'd1, 8'h04, 8'h00, 8'h00, '0), 1'b0);

		// Cheat file
		cheat_bytes = {$random(seed), $random(seed), $random(seed), $random(seed)};
		exp_cheat = ref_cheat(cheat_bytes);
		expect_writes = 0;
		write_count = 0;
		cheat_count = 0;
		done_before = load_done;
		download_type = FILETYPE_CHEAT;
		download_active = 1'b1;
		@(negedge clk);
		for (int i = 0; i < 16; i++)
			stream_byte(mem_addr_t'(i), cheat_bytes[8 * i +: 8]);
		repeat (3) @(negedge clk);
		check(cheat_count, 1, "cheat_load pulse count");
		check(load_done, done_before, "load_done during cheat file");
		download_active = 1'b0;
		repeat (2) @(negedge clk);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== vlog.f ====
source/cart_loader_pkg.sv
source/ines_header_parser.sv
source/rom_load_sequencer.sv
source/cheat_code_assembler.sv
source/cart_loader_top.sv
tests/tb_cart_loader.sv

// ==== Bender.yml ====
package:
  name: cart_loader

sources:
  - source/cart_loader_pkg.sv
  - source/ines_header_parser.sv
  - source/rom_load_sequencer.sv
  - source/cheat_code_assembler.sv
  - source/cart_loader_top.sv
  - target: test
    files:
      - tests/tb_cart_loader.sv
